// ==== Bender.yml ====
package:
  name: pc_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - pc_ctrl_pkg.sv
      - cf_decode.sv
      - branch_cmp.sv
      - next_pc_sel.sv
      - pc_unit_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pc_unit.sv

// ==== branch_cmp.sv ====
`timescale 1ns/1ps
`include "pc_cfg.svh"

module branch_cmp (
   input  pc_ctrl_pkg::cmp_op_e cmp_op,
   input  logic [`PC_XLEN-1:0]  a,
   input  logic [`PC_XLEN-1:0]  b,
   output logic                 taken
);

   logic eq;
   logic lt_s;
   logic lt_u;

   // three shared compares feed all six outcomes
   assign eq   = (a == b);
   assign lt_s = ($signed(a) < $signed(b));
   assign lt_u = (a < b);

   always_comb begin
      case (cmp_op)
         pc_ctrl_pkg::cmp_eq:  taken = eq;
         pc_ctrl_pkg::cmp_ne:  taken = !eq;
         pc_ctrl_pkg::cmp_lt:  taken = lt_s;
         pc_ctrl_pkg::cmp_ge:  taken = !lt_s;
         pc_ctrl_pkg::cmp_ltu: taken = lt_u;
         pc_ctrl_pkg::cmp_geu: taken = !lt_u;
         default:              taken = 1'b0;
      endcase
   end

endmodule

// ==== cf_decode.sv ====
`timescale 1ns/1ps
`include "pc_cfg.svh"

module cf_decode (
   input  rv_isa_pkg::rv_instr_u   instr,
   output pc_ctrl_pkg::flow_kind_e kind,
   output pc_ctrl_pkg::cmp_op_e    cmp_op,
   output logic [`PC_XLEN-1:0]     imm
);

   logic [`PC_XLEN-1:0] b_imm;
   logic [`PC_XLEN-1:0] j_imm;
   logic [`PC_XLEN-1:0] i_imm;
   logic                is_ebreak;

   assign b_imm = {{(`PC_XLEN-13){instr.b_fmt.imm_12}},
                   instr.b_fmt.imm_12,
                   instr.b_fmt.imm_11,
                   instr.b_fmt.imm_10_5,
                   instr.b_fmt.imm_4_1,
                   1'b0};

   // J layout gathered out of the I fields
   assign j_imm = {{(`PC_XLEN-21){instr.i_fmt.imm[11]}},
                   instr.i_fmt.imm[11],
                   instr.i_fmt.rs1,
                   instr.i_fmt.funct3,
                   instr.i_fmt.imm[0],
                   instr.i_fmt.imm[10:1],
                   1'b0};

   assign i_imm = {{(`PC_XLEN-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};

   assign is_ebreak = (instr.i_fmt.imm == 12'h001) &&
                      (instr.i_fmt.rs1 == 5'd0) &&
                      (instr.i_fmt.funct3 == 3'b000) &&
                      (instr.i_fmt.rd == 5'd0);

   always_comb begin
      kind   = pc_ctrl_pkg::flow_seq;
      cmp_op = pc_ctrl_pkg::cmp_eq;
      imm    = '0;
      case (instr.i_fmt.opcode)
         rv_isa_pkg::op_branch: begin
            kind = pc_ctrl_pkg::flow_branch;
            imm  = b_imm;
            case (instr.b_fmt.funct3)
               rv_isa_pkg::f3_beq:  cmp_op = pc_ctrl_pkg::cmp_eq;
               rv_isa_pkg::f3_bne:  cmp_op = pc_ctrl_pkg::cmp_ne;
               rv_isa_pkg::f3_blt:  cmp_op = pc_ctrl_pkg::cmp_lt;
               rv_isa_pkg::f3_bge:  cmp_op = pc_ctrl_pkg::cmp_ge;
               rv_isa_pkg::f3_bltu: cmp_op = pc_ctrl_pkg::cmp_ltu;
               rv_isa_pkg::f3_bgeu: cmp_op = pc_ctrl_pkg::cmp_geu;
               default: begin
                  kind = pc_ctrl_pkg::flow_seq; // reserved funct3
                  imm  = '0;
               end
            endcase
         end
         rv_isa_pkg::op_jal: begin
            kind = pc_ctrl_pkg::flow_jal;
            imm  = j_imm;
         end
         rv_isa_pkg::op_jalr: begin
            kind = pc_ctrl_pkg::flow_jalr;
            imm  = i_imm;
         end
         rv_isa_pkg::op_system: begin
            if (is_ebreak) begin
               kind = pc_ctrl_pkg::flow_ebreak;
            end
         end
         default: begin
            kind = pc_ctrl_pkg::flow_seq;
         end
      endcase
   end

endmodule

// ==== next_pc_sel.sv ====
`timescale 1ns/1ps
`include "pc_cfg.svh"

module next_pc_sel (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    instr_valid,
   input  pc_ctrl_pkg::flow_kind_e kind,
   input  logic                    taken,
   input  logic [`PC_XLEN-1:0]     imm,
   input  logic [`PC_XLEN-1:0]     rs1_data,
   input  logic                    rs1_pending,
   input  logic                    rs1_fwd_valid,
   input  logic [`PC_XLEN-1:0]     rs1_fwd_data,
   output logic [`PC_XLEN-1:0]     pc,
   output logic                    stall,
   output logic                    halt
);

   logic [`PC_XLEN-1:0] jalr_imm;
   logic [`PC_XLEN-1:0] seq_pc;
   logic [`PC_XLEN-1:0] rel_pc;
   logic [`PC_XLEN-1:0] reg_sum;
   logic [`PC_XLEN-1:0] fwd_sum;
   logic [`PC_XLEN-1:0] reg_target;
   logic [`PC_XLEN-1:0] fwd_target;
   logic [`PC_XLEN-1:0] pc_next;
   logic                stall_next;
   logic                halt_next;
   logic                accept;
   logic                jalr_wait;

   // strobes are dropped while waiting or halted
   assign accept    = instr_valid && !stall && !halt;
   assign jalr_wait = accept && (kind == pc_ctrl_pkg::flow_jalr) && rs1_pending;

   assign seq_pc  = pc + `PC_XLEN'd4;
   assign rel_pc  = pc + imm;
   assign reg_sum = rs1_data + imm;
   assign fwd_sum = rs1_fwd_data + jalr_imm;

   assign reg_target = {reg_sum[`PC_XLEN-1:1], 1'b0}; // jalr lsb cleared
   assign fwd_target = {fwd_sum[`PC_XLEN-1:1], 1'b0};

   always_comb begin
      pc_next    = pc;
      stall_next = stall;
      halt_next  = halt;
      if (stall) begin
         if (rs1_fwd_valid) begin
            pc_next    = fwd_target;
            stall_next = 1'b0;
         end
      end else if (accept) begin
         case (kind)
            pc_ctrl_pkg::flow_seq:    pc_next = seq_pc;
            pc_ctrl_pkg::flow_branch: pc_next = taken ? rel_pc : seq_pc;
            pc_ctrl_pkg::flow_jal:    pc_next = rel_pc;
            pc_ctrl_pkg::flow_jalr: begin
               if (rs1_pending) begin
                  stall_next = 1'b1; // base still in flight
               end else begin
                  pc_next = reg_target;
               end
            end
            pc_ctrl_pkg::flow_ebreak: begin
               pc_next   = `PC_TRAP_VEC;
               halt_next = 1'b1;
            end
            default: pc_next = pc;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc    <= `PC_RESET_VEC;
         stall <= 1'b0;
         halt  <= 1'b0;
      end else begin
         pc    <= pc_next;
         stall <= stall_next;
         halt  <= halt_next;
      end
   end

   // offset kept for the forwarded target
   always_ff @(posedge clk) begin
      if (jalr_wait) begin
         jalr_imm <= imm;
      end
   end

endmodule

// ==== pc_cfg.svh ====
`ifndef PC_CFG_SVH
`define PC_CFG_SVH

// register and pc width
`define PC_XLEN 64

// pc value after reset
`define PC_RESET_VEC 64'h0000_0000_8000_0000

// ebreak redirect target
`define PC_TRAP_VEC 64'h0000_0000_8000_0000

`endif

// ==== pc_ctrl_pkg.sv ====
package pc_ctrl_pkg;

   // branch comparison selected from funct3
   typedef enum logic [2:0] {
      cmp_eq  = 3'd0,
      cmp_ne  = 3'd1,
      cmp_lt  = 3'd2,
      cmp_ge  = 3'd3,
      cmp_ltu = 3'd4,
      cmp_geu = 3'd5
   } cmp_op_e;

   // control-flow class of the strobed instruction
   typedef enum logic [2:0] {
      flow_seq    = 3'd0,
      flow_branch = 3'd1,
      flow_jal    = 3'd2,
      flow_jalr   = 3'd3,
      flow_ebreak = 3'd4
   } flow_kind_e;

endpackage

// ==== pc_unit_top.sv ====
`timescale 1ns/1ps
`include "pc_cfg.svh"

module pc_unit_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  instr_valid,
   input  rv_isa_pkg::rv_instr_u instr,
   input  logic [`PC_XLEN-1:0]   rs1_data,
   input  logic [`PC_XLEN-1:0]   rs2_data,
   input  logic                  rs1_pending,
   input  logic                  rs1_fwd_valid,
   input  logic [`PC_XLEN-1:0]   rs1_fwd_data,
   output logic [`PC_XLEN-1:0]   pc,
   output logic                  stall,
   output logic                  halt
);

   pc_ctrl_pkg::flow_kind_e kind;
   pc_ctrl_pkg::cmp_op_e    cmp_op;
   logic [`PC_XLEN-1:0]     imm;
   logic                    taken;

   cf_decode u_decode (
      .instr  (instr),
      .kind   (kind),
      .cmp_op (cmp_op),
      .imm    (imm)
   );

   branch_cmp u_cmp (
      .cmp_op (cmp_op),
      .a      (rs1_data),
      .b      (rs2_data),
      .taken  (taken)
   );

   next_pc_sel u_sel (
      .clk           (clk),
      .rst_n         (rst_n),
      .instr_valid   (instr_valid),
      .kind          (kind),
      .taken         (taken),
      .imm           (imm),
      .rs1_data      (rs1_data),
      .rs1_pending   (rs1_pending),
      .rs1_fwd_valid (rs1_fwd_valid),
      .rs1_fwd_data  (rs1_fwd_data),
      .pc            (pc),
      .stall         (stall),
      .halt          (halt)
   );

endmodule

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_jal    = 7'b1101111;
   localparam logic [6:0] op_jalr   = 7'b1100111;
   localparam logic [6:0] op_system = 7'b1110011;

   localparam logic [2:0] f3_beq  = 3'b000;
   localparam logic [2:0] f3_bne  = 3'b001;
   localparam logic [2:0] f3_blt  = 3'b100;
   localparam logic [2:0] f3_bge  = 3'b101;
   localparam logic [2:0] f3_bltu = 3'b110;
   localparam logic [2:0] f3_bgeu = 3'b111;

   // I view which also feeds the J immediate
   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } rv_i_fmt_t;

   // B view with immediate bits scattered around rs1/rs2
   typedef struct packed {
      logic        imm_12;
      logic [5:0]  imm_10_5;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [3:0]  imm_4_1;
      logic        imm_11;
      logic [6:0]  opcode;
   } rv_b_fmt_t;

   typedef union packed {
      rv_i_fmt_t i_fmt;
      rv_b_fmt_t b_fmt;
   } rv_instr_u;

endpackage

// ==== src.f ====
+incdir+.
rv_isa_pkg.sv
pc_ctrl_pkg.sv
cf_decode.sv
branch_cmp.sv
next_pc_sel.sv
pc_unit_top.sv
tb_pc_unit.sv

// ==== tb_pc_vectors.svh ====
`ifndef TB_PC_VECTORS_SVH
`define TB_PC_VECTORS_SVH

localparam int NUM_VECS  = 30;
localparam int MAX_DELAY = 3;

// column order is instr, rs1, rs2, operand mode, pending, fwd delay, fwd value, pc, halt
// operand mode 1 is random signed and 2 is random unsigned-large; expected pc is then the
// taken target and the loop works out the outcome
task automatic load_vectors();
   add_vec(32'h0000_0013, 64'd0, 64'd0, 0, 0, 0, 64'd0, 64'h8000_0004, 0); // addi
   add_vec(32'h0000_0013, 64'd0, 64'd0, 0, 0, 0, 64'd0, 64'h8000_0008, 0);
   add_vec(enc_b(3'b000, 16), 64'd5, 64'd5, 0, 0, 0, 64'd0, 64'h8000_0018, 0); // beq
   add_vec(enc_b(3'b000, 16), 64'd5, 64'd6, 0, 0, 0, 64'd0, 64'h8000_001c, 0);
   add_vec(enc_b(3'b001, -12), 64'd5, 64'd6, 0, 0, 0, 64'd0, 64'h8000_0010, 0); // bne
   add_vec(enc_b(3'b001, -12), 64'd7, 64'd7, 0, 0, 0, 64'd0, 64'h8000_0014, 0);
   add_vec(enc_b(3'b100, 32), 64'hffff_ffff_ffff_ffff, 64'd1, 0, 0, 0, 64'd0,
           64'h8000_0034, 0); // blt
   add_vec(enc_b(3'b100, 32), 64'd1, 64'hffff_ffff_ffff_ffff, 0, 0, 0, 64'd0,
           64'h8000_0038, 0);
   add_vec(enc_b(3'b101, -16), 64'd1, 64'hffff_ffff_ffff_ffff, 0, 0, 0, 64'd0,
           64'h8000_0028, 0); // bge
   add_vec(enc_b(3'b101, -16), 64'hffff_ffff_ffff_fffe, 64'd3, 0, 0, 0, 64'd0,
           64'h8000_002c, 0);
   add_vec(enc_b(3'b110, 64), 64'd1, 64'hffff_ffff_ffff_ffff, 0, 0, 0, 64'd0,
           64'h8000_006c, 0); // bltu
   add_vec(enc_b(3'b110, 64), 64'hffff_ffff_ffff_ffff, 64'd1, 0, 0, 0, 64'd0,
           64'h8000_0070, 0);
   add_vec(enc_b(3'b111, -32), 64'hffff_ffff_ffff_ffff, 64'd1, 0, 0, 0, 64'd0,
           64'h8000_0050, 0); // bgeu
   add_vec(enc_b(3'b111, -32), 64'd1, 64'hffff_ffff_ffff_ffff, 0, 0, 0, 64'd0,
           64'h8000_0054, 0);
   add_vec(enc_b(3'b101, 8), 64'd9, 64'd9, 0, 0, 0, 64'd0, 64'h8000_005c, 0); // equal
   add_vec(enc_b(3'b110, 8), 64'd9, 64'd9, 0, 0, 0, 64'd0, 64'h8000_0060, 0);
   add_vec(enc_b(3'b100, 24), 64'd0, 64'd0, 1, 0, 0, 64'd0, 64'h8000_0078, 0); // random
   add_vec(enc_jalr(0), 64'h8000_0100, 64'd0, 0, 0, 0, 64'd0, 64'h8000_0100, 0);
   add_vec(enc_b(3'b111, -40), 64'd0, 64'd0, 2, 0, 0, 64'd0, 64'h8000_00d8, 0);
   add_vec(enc_jalr(16), 64'h8000_0201, 64'd0, 0, 0, 0, 64'd0, 64'h8000_0210, 0);
   add_vec(enc_j(256), 64'd0, 64'd0, 0, 0, 0, 64'd0, 64'h8000_0310, 0); // jal
   add_vec(enc_j(-512), 64'd0, 64'd0, 0, 0, 0, 64'd0, 64'h8000_0110, 0);
   add_vec(enc_jalr(-4), 64'h9000_0000, 64'd0, 0, 0, 0, 64'd0, 64'h8fff_fffc, 0);
   add_vec(enc_jalr(8), 64'hdead_beef, 64'd0, 0, 1, 1, 64'h8000_0401,
           64'h8000_0408, 0); // delayed jalr
   add_vec(enc_jalr(-16), 64'hdead_beef, 64'd0, 0, 1, 2, 64'h8000_0800,
           64'h8000_07f0, 0);
   add_vec(enc_jalr(0), 64'hdead_beef, 64'd0, 0, 1, 3, 64'h8000_1003,
           64'h8000_1002, 0);
   add_vec(32'h0000_0013, 64'd0, 64'd0, 0, 0, 0, 64'd0, 64'h8000_1006, 0);
   add_vec(32'h0010_0073, 64'd0, 64'd0, 0, 0, 0, 64'd0, 64'h8000_0000, 1); // ebreak
   add_vec(32'h0000_0013, 64'd0, 64'd0, 0, 0, 0, 64'd0, 64'h8000_0000, 1);
   add_vec(enc_j(256), 64'd0, 64'd0, 0, 0, 0, 64'd0, 64'h8000_0000, 1);
endtask

`endif

// ==== tb_pc_unit.sv ====
`timescale 1ns/1ps
`include "pc_cfg.svh"

module tb_pc_unit;

   logic                  clk;
   logic                  rst_n;
   logic                  instr_valid;
   rv_isa_pkg::rv_instr_u instr;
   logic [`PC_XLEN-1:0]   rs1_data;
   logic [`PC_XLEN-1:0]   rs2_data;
   logic                  rs1_pending;
   logic                  rs1_fwd_valid;
   logic [`PC_XLEN-1:0]   rs1_fwd_data;
   logic [`PC_XLEN-1:0]   pc;
   logic                  stall;
   logic                  halt;

   `include "tb_pc_vectors.svh"

   localparam int CYCLE_LIMIT = NUM_VECS * (MAX_DELAY + 4) + 20;

   logic [31:0]         vec_instr [NUM_VECS];
   logic [`PC_XLEN-1:0] vec_rs1 [NUM_VECS];
   logic [`PC_XLEN-1:0] vec_rs2 [NUM_VECS];
   int                  vec_opnd [NUM_VECS];
   logic                vec_pend [NUM_VECS];
   int                  vec_delay [NUM_VECS];
   logic [`PC_XLEN-1:0] vec_fwd [NUM_VECS];
   logic [`PC_XLEN-1:0] vec_exp_pc [NUM_VECS];
   logic                vec_halt [NUM_VECS];

   int                  vec_count = 0;
   int                  pc_errors = 0;
   int                  flag_errors = 0;
   int                  cycle_count = 0;
   integer              seed;
   logic [`PC_XLEN-1:0] exp_prev;

   pc_unit_top u_dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .instr_valid   (instr_valid),
      .instr         (instr),
      .rs1_data      (rs1_data),
      .rs2_data      (rs2_data),
      .rs1_pending   (rs1_pending),
      .rs1_fwd_valid (rs1_fwd_valid),
      .rs1_fwd_data  (rs1_fwd_data),
      .pc            (pc),
      .stall         (stall),
      .halt          (halt)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // B-type word on rs1 = x1 and rs2 = x2
   function automatic logic [31:0] enc_b(input logic [2:0] f3, input int imm);
      logic [12:0] v;
      v = imm[12:0];
      return {v[12], v[10:5], 5'd2, 5'd1, f3, v[4:1], v[11], rv_isa_pkg::op_branch};
   endfunction

   function automatic logic [31:0] enc_j(input int imm);
      logic [20:0] v;
      v = imm[20:0];
      return {v[20], v[10:1], v[11], v[19:12], 5'd1, rv_isa_pkg::op_jal};
   endfunction

   function automatic logic [31:0] enc_jalr(input int imm);
      logic [11:0] v;
      v = imm[11:0];
      return {v, 5'd1, 3'b000, 5'd1, rv_isa_pkg::op_jalr};
   endfunction

   // branch condition from funct3 per the ISA
   function automatic logic branch_holds(input logic [2:0] f3, input logic [`PC_XLEN-1:0] a,
                                         input logic [`PC_XLEN-1:0] b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return $signed(a) >= $signed(b);
         3'b110:  return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic add_vec(input logic [31:0] w, input logic [`PC_XLEN-1:0] a,
                          input logic [`PC_XLEN-1:0] b, input int opnd, input logic pend,
                          input int delay, input logic [`PC_XLEN-1:0] fwd,
                          input logic [`PC_XLEN-1:0] exp_val, input logic hlt);
      vec_instr[vec_count]  = w;
      vec_rs1[vec_count]    = a;
      vec_rs2[vec_count]    = b;
      vec_opnd[vec_count]   = opnd;
      vec_pend[vec_count]   = pend;
      vec_delay[vec_count]  = delay;
      vec_fwd[vec_count]    = fwd;
      vec_exp_pc[vec_count] = exp_val;
      vec_halt[vec_count]   = hlt;
      vec_count++;
   endtask

   task automatic check_pc(input string name, input logic [`PC_XLEN-1:0] exp_val,
                           input logic [`PC_XLEN-1:0] act);
      if (act !== exp_val) begin
         pc_errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp_val, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp_val, input logic act);
      if (act !== exp_val) begin
         flag_errors++;
         $display("** Error at %0t: %s expected %b, got %b", $time, name, exp_val, act);
      end
   endtask

   task automatic run_vector(input int i);
      logic [`PC_XLEN-1:0] a;
      logic [`PC_XLEN-1:0] b;
      logic [`PC_XLEN-1:0] exp_pc;
      a      = vec_rs1[i];
      b      = vec_rs2[i];
      exp_pc = vec_exp_pc[i];
      if (vec_opnd[i] != 0) begin
         a     = {$random(seed), $random(seed)};
         b     = {$random(seed), $random(seed)};
         a[`PC_XLEN-1] = 1'b1; // negative or large
         if (vec_opnd[i] == 2) begin
            b[`PC_XLEN-1] = 1'b1;
         end
         exp_pc = branch_holds(vec_instr[i][14:12], a, b) ? vec_exp_pc[i] : exp_prev + 4;
      end
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= vec_instr[i];
      rs1_data    <= a;
      rs2_data    <= b;
      rs1_pending <= vec_pend[i];
      @(posedge clk);
      instr_valid <= 1'b0;
      rs1_pending <= 1'b0;
      @(negedge clk);
      if (vec_pend[i]) begin
         check_flag("stall", 1'b1, stall);
         check_pc("pc", exp_prev, pc);
         repeat (vec_delay[i] - 1) begin
            @(posedge clk);
            @(negedge clk);
            check_flag("stall", 1'b1, stall);
            check_pc("pc", exp_prev, pc);
         end
         @(posedge clk);
         rs1_fwd_valid <= 1'b1;
         rs1_fwd_data  <= vec_fwd[i];
         @(posedge clk);
         rs1_fwd_valid <= 1'b0;
         @(negedge clk);
      end
      check_pc("pc", exp_pc, pc);
      check_flag("stall", 1'b0, stall);
      check_flag("halt", vec_halt[i], halt);
      @(posedge clk);
      @(negedge clk);
      check_pc("pc", exp_pc, pc); // idle cycle holds
      exp_prev = exp_pc;
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
         $display("tests failed");
         $finish;
      end
   end

   initial begin
      seed          = 32'h03d7926a;
      rst_n         = 1'b0;
      instr_valid   = 1'b0;
      instr         = '0;
      rs1_data      = '0;
      rs2_data      = '0;
      rs1_pending   = 1'b0;
      rs1_fwd_valid = 1'b0;
      rs1_fwd_data  = '0;
      load_vectors();
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_pc("pc", `PC_RESET_VEC, pc);
      check_flag("stall", 1'b0, stall);
      check_flag("halt", 1'b0, halt);
      exp_prev = `PC_RESET_VEC;
      for (int i = 0; i < vec_count; i++) begin
         run_vector(i);
      end
      $display("pc errors: %0d, flag errors: %0d", pc_errors, flag_errors);
      if (pc_errors + flag_errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule
